// File: design/rv_alu.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_alu import rv_pkg::*; (
    input  word_t   a_i,
    input  word_t   b_i,
    input  alu_op_e op_i,
    output word_t   y_o,
    output logic    zero_o
);

    logic lt;

    assign lt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ALU_ADD: y_o = a_i + b_i;
            ALU_SUB: y_o = a_i - b_i;
            ALU_AND: y_o = a_i & b_i;
            ALU_OR:  y_o = a_i | b_i;
            ALU_SLT: y_o = {{(`RV_XLEN-1){1'b0}}, lt};
            default: y_o = '0;
        endcase
    end

    assign zero_o = (y_o == '0);  // beq/bne test

endmodule

// File: design/rv_control.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_control import rv_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     run_i,
    input  word_t    instr_i,        // decode stage instruction
    input  ctrl_t    ex_ctrl_i,      // execute stage control
    input  logic     zero_i,
    input  logic     ex_imm_zero_i,
    output ctrl_t    ctrl_o,
    output imm_src_e imm_src_o,
    output logic     take_o,
    output logic     flush_o,
    output logic     done_o
);

    logic [2:0] funct3;
    logic       funct7_b5;
    logic       arith;      // r-type or i-type alu instruction
    logic       is_r;
    ctrl_t      dec;
    alu_op_e    alu_op;
    logic       done_q;

    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    // main decoder
    always_comb begin
        dec       = '0;
        imm_src_o = IMM_I;
        arith     = 1'b0;
        is_r      = 1'b0;
        case (opcode_e'(instr_i[6:0]))
            OP_R: begin
                dec.reg_write = 1'b1;
                arith         = 1'b1;
                is_r          = 1'b1;
            end
            OP_I: begin
                dec.reg_write = 1'b1;
                dec.alu_src   = 1'b1;
                arith         = 1'b1;
            end
            OP_LOAD: begin
                dec.reg_write  = 1'b1;
                dec.alu_src    = 1'b1;
                dec.result_src = RES_MEM;
            end
            OP_STORE: begin
                dec.mem_write = 1'b1;
                dec.alu_src   = 1'b1;
                imm_src_o     = IMM_S;
            end
            OP_BRANCH: begin
                dec.branch = 1'b1;
                dec.bne    = funct3[0];   // 000 beq, 001 bne
                dec.alu_op = ALU_SUB;     // compare by subtraction
                imm_src_o  = IMM_B;
            end
            OP_JAL: begin
                dec.reg_write  = 1'b1;
                dec.jump       = 1'b1;
                dec.result_src = RES_PC4; // link
                imm_src_o      = IMM_J;
            end
            default: dec = '0;            // unknown opcodes act as bubbles
        endcase
    end

    // alu decoder, funct7 bit 5 only matters for register operands
    always_comb begin
        alu_op = dec.alu_op;
        if (arith) begin
            case (funct3)
                3'b000:  alu_op = (is_r && funct7_b5) ? ALU_SUB : ALU_ADD;
                3'b010:  alu_op = ALU_SLT;
                3'b110:  alu_op = ALU_OR;
                3'b111:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        ctrl_o        = dec;
        ctrl_o.alu_op = alu_op;
    end

    // execute stage redirect
    assign take_o  = ex_ctrl_i.jump | (ex_ctrl_i.branch & (zero_i ^ ex_ctrl_i.bne));
    assign flush_o = take_o;  // kills the if_id and id_ex slots

    // a jal to itself ends the program
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || !run_i) begin
            done_q <= 1'b0;
        end else if (take_o && ex_ctrl_i.jump && ex_imm_zero_i) begin
            done_q <= 1'b1;
        end
    end

    assign done_o = done_q;

endmodule

// File: design/rv_core_top.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_core_top import rv_pkg::*; (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             run_i,
    input  logic                             prog_valid_i,
    input  logic [$clog2(`RV_IMEM_WORDS)-1:0] prog_addr_i,
    input  word_t                            prog_data_i,
    output logic                             prog_ready_o,
    output word_t                            a0_o,
    output logic                             done_o
);

    word_t    pc_q;
    word_t    pc_plus4;
    word_t    pc_target;
    word_t    instr_f;
    logic     take;
    logic     flush;
    logic     hold;        // reset or stopped, stages fill with bubbles

    if_id_t   if_id_q;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_q;

    ctrl_t    ctrl_d;
    imm_src_e imm_src;
    word_t    rd1_d;
    word_t    rd2_d;
    word_t    imm_d;
    word_t    alu_b;
    word_t    alu_y;
    logic     alu_zero;
    word_t    read_data_m;
    word_t    result_w;

    assign hold = ~rst_n_i | ~run_i;

    // fetch
    assign pc_plus4  = pc_q + 4;
    assign pc_target = id_ex_q.pc + id_ex_q.imm;

    always_ff @(posedge clk_i) begin
        if (hold) pc_q <= '0;
        else      pc_q <= take ? pc_target : pc_plus4;
    end

    rv_imem u_imem (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .prog_valid_i (prog_valid_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .prog_ready_o (prog_ready_o),
        .addr_i       (pc_q),
        .instr_o      (instr_f)
    );

    always_ff @(posedge clk_i) begin
        if (hold || flush) begin
            if_id_q       <= '0;
            if_id_q.instr <= `RV_NOP;
        end else begin
            if_id_q <= '{instr: instr_f, pc: pc_q, pc_plus4: pc_plus4};
        end
    end

    // decode
    rv_control u_control (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .run_i         (run_i),
        .instr_i       (if_id_q.instr),
        .ex_ctrl_i     (id_ex_q.ctrl),
        .zero_i        (alu_zero),
        .ex_imm_zero_i (id_ex_q.imm == '0),
        .ctrl_o        (ctrl_d),
        .imm_src_o     (imm_src),
        .take_o        (take),
        .flush_o       (flush),
        .done_o        (done_o)
    );

    rv_regfile u_regfile (
        .clk_i (clk_i),
        .rs1_i (if_id_q.instr[19:15]),
        .rs2_i (if_id_q.instr[24:20]),
        .rd_i  (mem_wb_q.rd),
        .we_i  (mem_wb_q.reg_write),
        .wd_i  (result_w),
        .rd1_o (rd1_d),
        .rd2_o (rd2_d),
        .a0_o  (a0_o)
    );

    rv_imm_gen u_imm_gen (
        .instr_i   (if_id_q.instr),
        .imm_src_i (imm_src),
        .imm_o     (imm_d)
    );

    always_ff @(posedge clk_i) begin
        if (hold || flush) begin
            id_ex_q <= '0;  // all enables low
        end else begin
            id_ex_q <= '{ctrl: ctrl_d, rd1: rd1_d, rd2: rd2_d, rd: if_id_q.instr[11:7],
                         imm: imm_d, pc: if_id_q.pc, pc_plus4: if_id_q.pc_plus4};
        end
    end

    // execute
    assign alu_b = id_ex_q.ctrl.alu_src ? id_ex_q.imm : id_ex_q.rd2;

    rv_alu u_alu (
        .a_i    (id_ex_q.rd1),
        .b_i    (alu_b),
        .op_i   (id_ex_q.ctrl.alu_op),
        .y_o    (alu_y),
        .zero_o (alu_zero)
    );

    // the redirecting instruction itself goes on, jal still links
    always_ff @(posedge clk_i) begin
        if (hold) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q <= '{reg_write: id_ex_q.ctrl.reg_write,
                          mem_write: id_ex_q.ctrl.mem_write,
                          result_src: id_ex_q.ctrl.result_src,
                          alu_result: alu_y, write_data: id_ex_q.rd2,
                          rd: id_ex_q.rd, pc_plus4: id_ex_q.pc_plus4};
        end
    end

    // memory
    rv_dmem u_dmem (
        .clk_i   (clk_i),
        .addr_i  (ex_mem_q.alu_result),
        .wdata_i (ex_mem_q.write_data),
        .we_i    (ex_mem_q.mem_write),
        .rdata_o (read_data_m)
    );

    always_ff @(posedge clk_i) begin
        if (hold) begin
            mem_wb_q <= '0;
        end else begin
            mem_wb_q <= '{reg_write: ex_mem_q.reg_write, result_src: ex_mem_q.result_src,
                          alu_result: ex_mem_q.alu_result, read_data: read_data_m,
                          rd: ex_mem_q.rd, pc_plus4: ex_mem_q.pc_plus4};
        end
    end

    // writeback
    always_comb begin
        case (mem_wb_q.result_src)
            RES_MEM: result_w = mem_wb_q.read_data;
            RES_PC4: result_w = mem_wb_q.pc_plus4;
            default: result_w = mem_wb_q.alu_result;
        endcase
    end

endmodule

// File: design/rv_dmem.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_dmem import rv_pkg::*; (
    input  logic  clk_i,
    input  word_t addr_i,
    input  word_t wdata_i,
    input  logic  we_i,
    output word_t rdata_o
);

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    word_t mem [`RV_DMEM_WORDS];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[addr_i[AW+1:2]] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i[AW+1:2]];  // word accesses only

endmodule

// File: design/rv_imem.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_imem import rv_pkg::*; #(
    parameter int AW = $clog2(`RV_IMEM_WORDS)
) (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  logic          run_i,
    input  logic          prog_valid_i,
    input  logic [AW-1:0] prog_addr_i,   // word index
    input  word_t         prog_data_i,
    output logic          prog_ready_o,
    input  word_t         addr_i,        // byte address from the pc
    output word_t         instr_o
);

    word_t mem [`RV_IMEM_WORDS];
    logic  load;

    // the array can only be loaded while the core is stopped
    assign prog_ready_o = ~run_i;

    // nothing is stored while the core is held in reset
    assign load = prog_valid_i & prog_ready_o & rst_n_i;

    always_ff @(posedge clk_i) begin
        if (load) begin
            mem[prog_addr_i] <= prog_data_i;
        end
    end

    assign instr_o = mem[addr_i[AW+1:2]];  // drop the byte offset

endmodule

// File: design/rv_imm_gen.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_imm_gen import rv_pkg::*; (
    input  word_t    instr_i,
    input  imm_src_e imm_src_i,
    output word_t    imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_src_i)
            IMM_I: imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:20]};
            IMM_S: imm_o = {{(`RV_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            // b and j offsets are in halfwords, bit 0 is implied
            IMM_B: imm_o = {{(`RV_XLEN-13){sign}}, sign, instr_i[7],
                            instr_i[30:25], instr_i[11:8], 1'b0};
            IMM_J: imm_o = {{(`RV_XLEN-21){sign}}, sign, instr_i[19:12],
                            instr_i[20], instr_i[30:21], 1'b0};
            default: imm_o = '0;
        endcase
    end

endmodule

// File: design/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]   word_t;
    typedef logic [`RV_REG_AW-1:0] reg_addr_t;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_SLT = 4'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } result_src_e;

    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_B = 2'd2,
        IMM_J = 2'd3
    } imm_src_e;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        alu_src;    // 1 selects the immediate
        logic        branch;
        logic        bne;        // invert the zero test
        logic        jump;
        result_src_e result_src;
        alu_op_e     alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        word_t pc_plus4;
    } if_id_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     rd1;
        word_t     rd2;
        reg_addr_t rd;
        word_t     imm;
        word_t     pc;
        word_t     pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        result_src_e result_src;
        word_t       alu_result;
        word_t       write_data;
        reg_addr_t   rd;
        word_t       pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic        reg_write;
        result_src_e result_src;
        word_t       alu_result;
        word_t       read_data;
        reg_addr_t   rd;
        word_t       pc_plus4;
    } mem_wb_t;

endpackage

// File: design/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_regfile import rv_pkg::*; (
    input  logic      clk_i,
    input  reg_addr_t rs1_i,
    input  reg_addr_t rs2_i,
    input  reg_addr_t rd_i,
    input  logic      we_i,
    input  word_t     wd_i,
    output word_t     rd1_o,
    output word_t     rd2_o,
    output word_t     a0_o
);

    localparam int A0_IDX = 10;

    word_t regs [2**`RV_REG_AW];

    // x0 reads zero, a write in flight is returned directly
    function automatic word_t read_port(input reg_addr_t rs);
        if (rs == '0) return '0;
        if (we_i && (rd_i == rs)) return wd_i;
        return regs[rs];
    endfunction

    always_ff @(posedge clk_i) begin
        if (we_i && (rd_i != '0)) begin
            regs[rd_i] <= wd_i;
        end
    end

    assign rd1_o = read_port(rs1_i);
    assign rd2_o = read_port(rs2_i);
    assign a0_o  = regs[A0_IDX];

endmodule

// File: dv/rv_tb.sv
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_tb import rv_pkg::*; ();

    localparam int NUM_PROGS       = 20;
    localparam int CYCLES_PER_PROG = 200;
    localparam int TIMEOUT_CYCLES  = NUM_PROGS * CYCLES_PER_PROG;
    localparam int MAX_WORDS       = 60;
    localparam int IAW             = $clog2(`RV_IMEM_WORDS);

    logic           clk_i;
    logic           rst_n_i;
    logic           run_i;
    logic           prog_valid_i;
    logic [IAW-1:0] prog_addr_i;
    word_t          prog_data_i;
    logic           prog_ready_o;
    word_t          a0_o;
    logic           done_o;

    word_t       prog [`RV_IMEM_WORDS];
    int          prog_len;
    word_t       mregs [32];              // model state kept across programs
    word_t       mmem [`RV_DMEM_WORDS];
    logic        reg_ok [16];             // registers holding a known value
    int          errors;
    int          checks;
    int          cycle_cnt;

    rv_core_top uut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .run_i        (run_i),
        .prog_valid_i (prog_valid_i),
        .prog_addr_i  (prog_addr_i),
        .prog_data_i  (prog_data_i),
        .prog_ready_o (prog_ready_o),
        .a0_o         (a0_o),
        .done_o       (done_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a program never finished", cycle_cnt);
            $display("checks: %0d errors: %0d", checks, errors + 1);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    // rv32i encodings
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    function automatic reg_addr_t pick_src();
        reg_addr_t r;
        r = 5'($urandom_range(15, 0));
        while (!reg_ok[r]) r = 5'($urandom_range(15, 0));
        return r;
    endfunction

    task automatic emit(input word_t w);
        prog[prog_len] = w;
        prog_len++;
    endtask

    task automatic emit_nops();
        repeat (3) emit(`RV_NOP);
    endtask

    task automatic emit_shadows();  // two x10 writes right behind a redirect
        repeat (2) emit(enc_i(12'($urandom_range(4095, 0)), 5'd0, 3'b000, 5'd10, OP_I));
    endtask

    task automatic emit_alu(input reg_addr_t rd);
        int sel;
        sel = $urandom_range(7, 0);
        case (sel)
            0: emit(enc_r(7'h00, pick_src(), pick_src(), 3'b000, rd));  // add
            1: emit(enc_r(7'h20, pick_src(), pick_src(), 3'b000, rd));  // sub
            2: emit(enc_r(7'h00, pick_src(), pick_src(), 3'b111, rd));
            3: emit(enc_r(7'h00, pick_src(), pick_src(), 3'b110, rd));
            4: emit(enc_r(7'h00, pick_src(), pick_src(), 3'b010, rd));  // slt
            default: emit(enc_i(12'($urandom_range(4095, 0)), pick_src(), 3'b000, rd, OP_I));
        endcase
        reg_ok[rd] = 1'b1;
        emit_nops();
    endtask

    // forward-only program with three nops after each instruction
    task automatic gen_program();
        int          kind;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] off;
        prog_len = 0;
        while (prog_len + 17 <= MAX_WORDS) begin
            kind = $urandom_range(4, 0);
            case (kind)
                0, 1: emit_alu(5'($urandom_range(15, 1)));
                2: begin  // store, load back, sum into x10
                    off = 12'($urandom_range(`RV_DMEM_WORDS - 1, 0) * 4);
                    rd  = 5'($urandom_range(15, 1));
                    emit(enc_s(off, pick_src(), 5'd0));
                    emit_nops();
                    emit(enc_i(off, 5'd0, 3'b010, rd, OP_LOAD));
                    emit_nops();
                    reg_ok[rd] = 1'b1;
                    emit(enc_r(7'h00, rd, reg_ok[10] ? 5'd10 : 5'd0, 3'b000, 5'd10));
                    emit_nops();
                    reg_ok[10] = 1'b1;
                end
                3: begin
                    rs1 = pick_src();
                    rs2 = $urandom_range(1, 0) ? rs1 : pick_src();  // bias towards equal
                    emit(enc_b(13'd24, rs2, rs1, $urandom_range(1, 0) ? 3'b001 : 3'b000));
                    emit_shadows();
                    emit_nops();
                end
                default: begin  // jal over the shadows then link copied into x10
                    rd = 5'($urandom_range(15, 1));
                    emit(enc_j(21'd24, rd));
                    emit_shadows();
                    emit_nops();
                    emit(enc_i(12'd0, rd, 3'b000, 5'd10, OP_I));
                    emit_nops();
                    reg_ok[rd] = 1'b1;
                    reg_ok[10] = 1'b1;
                end
            endcase
        end
        emit_alu(5'd10);
        emit(enc_j(21'd0, 5'd0));  // jal to itself
    endtask

    task automatic set_reg(input reg_addr_t rd, input word_t v);
        if (rd != '0) mregs[rd] = v;
    endtask

    // sequential instruction-set model
    task automatic run_model();
        word_t pc;
        word_t w;
        word_t a;
        word_t b;
        word_t r;
        word_t ea;
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_j;
        int    steps;
        logic  stop;
        pc    = '0;
        steps = 0;
        stop  = 1'b0;
        while (!stop && steps < MAX_WORDS) begin
            w     = prog[pc[7:2]];
            a     = mregs[w[19:15]];
            b     = mregs[w[24:20]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            r     = pc + 4;
            case (w[6:0])
                OP_R: begin
                    case (w[14:12])
                        3'b000:  set_reg(w[11:7], w[30] ? a - b : a + b);
                        3'b010:  set_reg(w[11:7], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        3'b110:  set_reg(w[11:7], a | b);
                        default: set_reg(w[11:7], a & b);
                    endcase
                end
                OP_I: set_reg(w[11:7], a + imm_i);
                OP_LOAD: begin
                    ea = a + imm_i;
                    set_reg(w[11:7], mmem[ea[7:2]]);
                end
                OP_STORE: begin
                    ea = a + imm_s;
                    mmem[ea[7:2]] = b;
                end
                OP_BRANCH: if ((a == b) != w[12]) r = pc + imm_b;
                OP_JAL: begin
                    set_reg(w[11:7], pc + 4);
                    stop = (imm_j == '0);
                    r    = pc + imm_j;
                end
                default: ;
            endcase
            pc = r;
            steps++;
        end
    endtask

    task automatic load_program();
        logic accepted;
        @(posedge clk_i);
        for (int i = 0; i < prog_len; i++) begin
            prog_valid_i <= 1'b1;
            prog_addr_i  <= IAW'(i);
            prog_data_i  <= prog[i];
            do begin
                @(negedge clk_i);
                accepted = prog_ready_o;
                check_bit("prog_ready_o", prog_ready_o, 1'b1);
                @(posedge clk_i);
            end while (!accepted);
        end
        prog_valid_i <= 1'b0;
    endtask

    task automatic run_program();
        logic finished;
        @(posedge clk_i);
        run_i        <= 1'b1;
        // a write over the closing x10 instruction that must be refused
        prog_valid_i <= 1'b1;
        prog_addr_i  <= IAW'(prog_len - 5);
        prog_data_i  <= enc_i(12'h5a5, 5'd0, 3'b000, 5'd10, OP_I);
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk_i);
            check_bit("prog_ready_o", prog_ready_o, 1'b0);
            finished = done_o;
        end
        check_word("a0_o", a0_o, mregs[10]);
        @(posedge clk_i);
        run_i        <= 1'b0;
        prog_valid_i <= 1'b0;
        @(posedge clk_i);
        @(negedge clk_i);
        check_bit("done_o", done_o, 1'b0);
        check_bit("prog_ready_o", prog_ready_o, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h5399_6921));
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        run_i        = 1'b0;
        prog_valid_i = 1'b0;
        prog_addr_i  = '0;
        prog_data_i  = '0;
        errors       = 0;
        checks       = 0;
        cycle_cnt    = 0;
        for (int i = 0; i < 32; i++) mregs[i] = '0;
        for (int i = 0; i < 16; i++) reg_ok[i] = (i == 0);
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        check_bit("done_o", done_o, 1'b0);
        check_bit("prog_ready_o", prog_ready_o, 1'b1);
        for (int p = 0; p < NUM_PROGS; p++) begin
            gen_program();
            run_model();
            load_program();
            run_program();
        end
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: include/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// datapath and pc width
`define RV_XLEN 32

// register file address width, 32 registers
`define RV_REG_AW 5

// memory depths in 32-bit words
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

// File: src.f
+incdir+include
design/rv_pkg.sv
design/rv_control.sv
design/rv_regfile.sv
design/rv_imm_gen.sv
design/rv_alu.sv
design/rv_imem.sv
design/rv_dmem.sv
design/rv_core_top.sv
dv/rv_tb.sv
